/* filelist.f */
+incdir+hdl
hdl/irq_sleep_pkg.sv
hdl/irq_csr_axil.sv
hdl/irq_arbiter.sv
hdl/bus_outstanding_tracker.sv
hdl/sleep_ctrl.sv
hdl/irq_sleep_top.sv
testbench/tb_irq_sleep.sv

/* hdl/bus_outstanding_tracker.sv */
// Outstanding transaction counter for one bus side, granted requests minus responses
`timescale 1ns/1ps
`default_nettype none

module bus_outstanding_tracker (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  logic                      gnt_i,
  input  logic                      rvalid_i,
  output irq_sleep_pkg::outst_cnt_t count_o
);

  import irq_sleep_pkg::*;

  outst_cnt_t count_q;
  logic       issue;

  // A request counts once the bus grants it
  assign issue = req_i & gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      if (issue && !rvalid_i) begin
        count_q <= count_q + outst_cnt_t'(1);
      end else if (rvalid_i && !issue) begin
        count_q <= count_q - outst_cnt_t'(1);
      end
      // Issue and response together leave the count as is
    end
  end

  assign count_o = count_q;

endmodule : bus_outstanding_tracker

`default_nettype wire

/* hdl/irq_arbiter.sv */
// Interrupt arbiter with pending register, enable masking and fixed-priority acknowledge
`timescale 1ns/1ps
`default_nettype none

`include "irq_sleep_defines.svh"

module irq_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  irq_sleep_pkg::irq_vec_t irq_i,
  input  irq_sleep_pkg::irq_vec_t mie_i,
  input  logic                    mstatus_mie_i,
  input  logic                    irq_ready_i,
  output irq_sleep_pkg::irq_vec_t mip_o,
  output logic                    irq_ack_o,
  output irq_sleep_pkg::irq_id_t  irq_id_o,
  output logic                    irq_wake_o
);

  import irq_sleep_pkg::*;

  irq_vec_t mip_q;
  irq_vec_t pend_en;
  irq_id_t  win_id;
  logic     take;
  logic     irq_ack_q;
  irq_id_t  irq_id_q;

  // Pending bits follow the inputs one cycle late, reserved lines dropped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & `IRQ_VALID_MASK;
    end
  end

  assign pend_en = mip_q & mie_i;

  // ------------------------------------------------
  // Priority select
  // ------------------------------------------------

  // Lowest priority first so that later hits override
  // Order from the top is 31..16, 11, 3, 7
  always_comb begin
    win_id = '0;
    if (pend_en[7]) begin
      win_id = irq_id_t'(7);
    end
    if (pend_en[3]) begin
      win_id = irq_id_t'(3);
    end
    if (pend_en[11]) begin
      win_id = irq_id_t'(11);
    end
    for (int i = 16; i < `IRQ_NUM; i++) begin
      if (pend_en[i]) begin
        win_id = irq_id_t'(i);
      end
    end
  end

  // Never two acknowledges back to back
  assign take = (|pend_en) & mstatus_mie_i & irq_ready_i & ~irq_ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_ack_q <= 1'b0;
    end else begin
      irq_ack_q <= take;
    end
  end

  // Id is only meaningful alongside the acknowledge
  always_ff @(posedge clk_i) begin
    if (take) begin
      irq_id_q <= win_id;
    end
  end

  assign mip_o      = mip_q;
  assign irq_ack_o  = irq_ack_q;
  assign irq_id_o   = irq_id_q;
  // Wake ignores the global enable
  assign irq_wake_o = |pend_en;

endmodule : irq_arbiter

`default_nettype wire

/* hdl/irq_csr_axil.sv */
// AXI4-Lite register block for interrupt enable, global enable, pending and last id
`timescale 1ns/1ps
`default_nettype none

`include "irq_sleep_defines.svh"

module irq_csr_axil (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Write address channel
  input  irq_sleep_pkg::csr_addr_t s_axil_awaddr_i,
  input  logic                     s_axil_awvalid_i,
  output logic                     s_axil_awready_o,
  // Write data channel
  input  irq_sleep_pkg::csr_data_t s_axil_wdata_i,
  input  logic                     s_axil_wvalid_i,
  output logic                     s_axil_wready_o,
  // Write response channel
  output logic [1:0]               s_axil_bresp_o,
  output logic                     s_axil_bvalid_o,
  input  logic                     s_axil_bready_i,
  // Read address channel
  input  irq_sleep_pkg::csr_addr_t s_axil_araddr_i,
  input  logic                     s_axil_arvalid_i,
  output logic                     s_axil_arready_o,
  // Read data channel
  output irq_sleep_pkg::csr_data_t s_axil_rdata_o,
  output logic [1:0]               s_axil_rresp_o,
  output logic                     s_axil_rvalid_o,
  input  logic                     s_axil_rready_i,
  // Arbiter side
  input  irq_sleep_pkg::irq_vec_t  mip_i,
  input  logic                     irq_ack_i,
  input  irq_sleep_pkg::irq_id_t   irq_id_i,
  output irq_sleep_pkg::irq_vec_t  mie_o,
  output logic                     mstatus_mie_o
);

  import irq_sleep_pkg::*;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Register state
  irq_vec_t   mie_q;
  logic       mstatus_mie_q;
  irq_id_t    last_id_q;

  // Channel handshake state
  logic       awready_q;
  logic       bvalid_q;
  logic       arready_q;
  logic       rvalid_q;
  logic [1:0] bresp_q;
  logic [1:0] rresp_q;
  csr_data_t  rdata_q;

  logic       wr_fire;
  logic       rd_fire;
  logic       wr_hit;
  logic       rd_hit;
  csr_data_t  rd_data;

  // Valid is held by the master across the ready pulse
  assign wr_fire = awready_q & s_axil_awvalid_i & s_axil_wvalid_i;
  assign rd_fire = arready_q & s_axil_arvalid_i;

  // ------------------------------------------------
  // Address decode
  // ------------------------------------------------

  // Read-only registers still count as mapped for writes
  always_comb begin
    case (s_axil_awaddr_i)
      `CSR_MIE_OFS, `CSR_MSTATUS_OFS, `CSR_MIP_OFS, `CSR_IRQ_ID_OFS: wr_hit = 1'b1;
      default: wr_hit = 1'b0;
    endcase
  end

  always_comb begin
    rd_data = '0;
    rd_hit  = 1'b1;
    case (s_axil_araddr_i)
      `CSR_MIE_OFS:     rd_data = mie_q;
      // Only the global enable is implemented in MSTATUS
      `CSR_MSTATUS_OFS: rd_data[`MSTATUS_MIE_BIT] = mstatus_mie_q;
      `CSR_MIP_OFS:     rd_data = mip_i;
      `CSR_IRQ_ID_OFS:  rd_data = csr_data_t'(last_id_q);
      default:          rd_hit = 1'b0;
    endcase
  end

  // ------------------------------------------------
  // Channel handshakes
  // ------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      awready_q <= 1'b0;
      bvalid_q  <= 1'b0;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      // One-cycle ready pulse, blocked while a response waits
      awready_q <= s_axil_awvalid_i & s_axil_wvalid_i & ~bvalid_q & ~awready_q;
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (s_axil_bready_i) begin
        bvalid_q <= 1'b0;
      end
      arready_q <= s_axil_arvalid_i & ~rvalid_q & ~arready_q;
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (s_axil_rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Response payload, only looked at while valid
  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      bresp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_fire) begin
      rdata_q <= rd_data;
      rresp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // ------------------------------------------------
  // Register updates
  // ------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q         <= '0;
      mstatus_mie_q <= 1'b0;
      last_id_q     <= '0;
    end else begin
      if (wr_fire && (s_axil_awaddr_i == `CSR_MIE_OFS)) begin
        mie_q <= s_axil_wdata_i & `IRQ_VALID_MASK;
      end
      if (wr_fire && (s_axil_awaddr_i == `CSR_MSTATUS_OFS)) begin
        mstatus_mie_q <= s_axil_wdata_i[`MSTATUS_MIE_BIT];
      end
      // Taking an interrupt wins over a software write
      if (irq_ack_i) begin
        mstatus_mie_q <= 1'b0;
        last_id_q     <= irq_id_i;
      end
    end
  end

  assign s_axil_awready_o = awready_q;
  assign s_axil_wready_o  = awready_q;
  assign s_axil_bvalid_o  = bvalid_q;
  assign s_axil_bresp_o   = bresp_q;
  assign s_axil_arready_o = arready_q;
  assign s_axil_rvalid_o  = rvalid_q;
  assign s_axil_rdata_o   = rdata_q;
  assign s_axil_rresp_o   = rresp_q;
  assign mie_o            = mie_q;
  assign mstatus_mie_o    = mstatus_mie_q;

endmodule : irq_csr_axil

`default_nettype wire

/* hdl/irq_sleep_defines.svh */
// Interrupt and sleep controller constants for line map, CSR map and counter sizes
`ifndef IRQ_SLEEP_DEFINES_SVH
`define IRQ_SLEEP_DEFINES_SVH

// ------------------------------------------------
// Interrupt lines
// ------------------------------------------------

// Number of machine interrupt lines
`define IRQ_NUM 32

// Implemented lines are 31..16, 11, 7 and 3
`define IRQ_VALID_MASK 32'hFFFF_0888

// ------------------------------------------------
// Register map
// ------------------------------------------------

`define CSR_ADDR_W 4

`define CSR_MIE_OFS     4'h0
`define CSR_MSTATUS_OFS 4'h4
`define CSR_MIP_OFS     4'h8
`define CSR_IRQ_ID_OFS  4'hC

// Global machine interrupt enable position in MSTATUS
`define MSTATUS_MIE_BIT 3

// Outstanding bus transaction counter width
`define OUTST_W 4

// Wait cycles between WFI retire and the idle check
`define SLEEP_ENTRY_DELAY 2

`endif

/* hdl/irq_sleep_pkg.sv */
// Shared vector types and sleep state encoding of the interrupt and sleep controller
`default_nettype none

`include "irq_sleep_defines.svh"

package irq_sleep_pkg;

  // One bit per machine interrupt line
  typedef logic [`IRQ_NUM-1:0] irq_vec_t;

  // Interrupt number, wide enough for any line
  typedef logic [$clog2(`IRQ_NUM)-1:0] irq_id_t;

  // AXI4-Lite register address and data
  typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;

  // Issued but unanswered requests on one bus side
  typedef logic [`OUTST_W-1:0] outst_cnt_t;

  // Sleep controller states
  typedef enum logic [1:0] {
    RUN,      // Core active
    WAIT,     // Counting down after WFI retire
    BLOCKED,  // Waiting for bus and write buffer to drain
    SLEEP     // Core asleep
  } sleep_state_e;

endpackage : irq_sleep_pkg

`default_nettype wire

/* hdl/irq_sleep_top.sv */
// Interrupt and sleep controller top with register block, arbiter, trackers and sleep FSM
`timescale 1ns/1ps
`default_nettype none

module irq_sleep_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Core interrupt interface
  input  irq_sleep_pkg::irq_vec_t  irq_i,
  input  logic                     irq_ready_i,
  output logic                     irq_ack_o,
  output irq_sleep_pkg::irq_id_t   irq_id_o,
  // Core sleep interface
  input  logic                     wfi_retire_i,
  input  logic                     debug_req_i,
  input  logic                     wbuf_empty_i,
  output logic                     core_sleep_o,
  // Instruction-side bus
  input  logic                     iside_req_i,
  input  logic                     iside_gnt_i,
  input  logic                     iside_rvalid_i,
  // Data-side bus
  input  logic                     dside_req_i,
  input  logic                     dside_gnt_i,
  input  logic                     dside_rvalid_i,
  // AXI4-Lite register port
  input  irq_sleep_pkg::csr_addr_t s_axil_awaddr_i,
  input  logic                     s_axil_awvalid_i,
  output logic                     s_axil_awready_o,
  input  irq_sleep_pkg::csr_data_t s_axil_wdata_i,
  input  logic                     s_axil_wvalid_i,
  output logic                     s_axil_wready_o,
  output logic [1:0]               s_axil_bresp_o,
  output logic                     s_axil_bvalid_o,
  input  logic                     s_axil_bready_i,
  input  irq_sleep_pkg::csr_addr_t s_axil_araddr_i,
  input  logic                     s_axil_arvalid_i,
  output logic                     s_axil_arready_o,
  output irq_sleep_pkg::csr_data_t s_axil_rdata_o,
  output logic [1:0]               s_axil_rresp_o,
  output logic                     s_axil_rvalid_o,
  input  logic                     s_axil_rready_i
);

  import irq_sleep_pkg::*;

  irq_vec_t   mie;
  logic       mstatus_mie;
  irq_vec_t   mip;
  logic       irq_wake;
  outst_cnt_t iside_count;
  outst_cnt_t dside_count;

  // ------------------------------------------------
  // Register block and arbiter
  // ------------------------------------------------

  irq_csr_axil u_csr (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .mip_i            (mip),
    .irq_ack_i        (irq_ack_o),
    .irq_id_i         (irq_id_o),
    .mie_o            (mie),
    .mstatus_mie_o    (mstatus_mie)
  );

  irq_arbiter u_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .irq_i         (irq_i),
    .mie_i         (mie),
    .mstatus_mie_i (mstatus_mie),
    .irq_ready_i   (irq_ready_i),
    .mip_o         (mip),
    .irq_ack_o     (irq_ack_o),
    .irq_id_o      (irq_id_o),
    .irq_wake_o    (irq_wake)
  );

  // ------------------------------------------------
  // Bus trackers and sleep control
  // ------------------------------------------------

  bus_outstanding_tracker u_iside_tracker (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (iside_req_i),
    .gnt_i    (iside_gnt_i),
    .rvalid_i (iside_rvalid_i),
    .count_o  (iside_count)
  );

  bus_outstanding_tracker u_dside_tracker (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (dside_req_i),
    .gnt_i    (dside_gnt_i),
    .rvalid_i (dside_rvalid_i),
    .count_o  (dside_count)
  );

  sleep_ctrl u_sleep_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wfi_retire_i  (wfi_retire_i),
    .irq_wake_i    (irq_wake),
    .debug_req_i   (debug_req_i),
    .iside_count_i (iside_count),
    .dside_count_i (dside_count),
    .wbuf_empty_i  (wbuf_empty_i),
    .core_sleep_o  (core_sleep_o)
  );

endmodule : irq_sleep_top

`default_nettype wire

/* hdl/sleep_ctrl.sv */
// WFI sleep controller with entry delay, bus drain wait and wake on interrupt or debug
`timescale 1ns/1ps
`default_nettype none

`include "irq_sleep_defines.svh"

module sleep_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      wfi_retire_i,
  input  logic                      irq_wake_i,
  input  logic                      debug_req_i,
  input  irq_sleep_pkg::outst_cnt_t iside_count_i,
  input  irq_sleep_pkg::outst_cnt_t dside_count_i,
  input  logic                      wbuf_empty_i,
  output logic                      core_sleep_o
);

  import irq_sleep_pkg::*;

  localparam int DLY_W = $clog2(`SLEEP_ENTRY_DELAY + 1);

  sleep_state_e     state_q;
  sleep_state_e     state_d;
  logic [DLY_W-1:0] dly_q;
  logic             wake;
  logic             idle;

  assign wake = irq_wake_i | debug_req_i;

  // Nothing in flight on either side and the write buffer drained
  assign idle = (iside_count_i == '0) & (dside_count_i == '0) & wbuf_empty_i;

  // ------------------------------------------------
  // Next state
  // ------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      RUN: begin
        if (wfi_retire_i && !wake) begin
          state_d = WAIT;
        end
      end
      // Delay cycles, then one idle check in BLOCKED at the earliest
      WAIT: begin
        if (wake) begin
          state_d = RUN;
        end else if (dly_q == DLY_W'(`SLEEP_ENTRY_DELAY - 1)) begin
          state_d = BLOCKED;
        end
      end
      BLOCKED: begin
        if (wake) begin
          state_d = RUN;
        end else if (idle) begin
          state_d = SLEEP;
        end
      end
      SLEEP: begin
        if (wake) begin
          state_d = RUN;
        end
      end
      default: state_d = RUN;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RUN;
      dly_q   <= '0;
    end else begin
      state_q <= state_d;
      // Counter restarts on every entry into WAIT
      if (state_q == WAIT) begin
        dly_q <= dly_q + DLY_W'(1);
      end else begin
        dly_q <= '0;
      end
    end
  end

  assign core_sleep_o = (state_q == SLEEP);

endmodule : sleep_ctrl

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, pass or fail from the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module tb_irq_sleep \
  -f filelist.f

./obj_dir/Vtb_irq_sleep > sim.log 2>&1
cat sim.log

if grep -qxF "Finished with no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

/* testbench/tb_irq_sleep.sv */
// Directed testbench for the interrupt and sleep controller with AXI4-Lite register access
`timescale 1ns/1ps
`default_nettype none

`include "irq_sleep_defines.svh"

module tb_irq_sleep;

  // Limit well above the few hundred cycles that all tests take together
  localparam int MAX_CYCLES = 3000;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [31:0] irq;
  logic        irq_ready;
  logic        irq_ack;
  logic [4:0]  irq_id;
  logic        wfi_retire;
  logic        debug_req;
  logic        wbuf_empty;
  logic        core_sleep;
  logic        iside_req;
  logic        iside_gnt;
  logic        iside_rvalid;
  logic        dside_req;
  logic        dside_gnt;
  logic        dside_rvalid;
  logic [3:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [3:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  int          error_count = 0;
  int          tests_run = 0;
  int          cycle_count = 0;
  int          ack_count = 0;
  logic [4:0]  ack_id_seen;
  logic [1:0]  resp;
  logic [31:0] rd;

  irq_sleep_top u_dut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .irq_i            (irq),
    .irq_ready_i      (irq_ready),
    .irq_ack_o        (irq_ack),
    .irq_id_o         (irq_id),
    .wfi_retire_i     (wfi_retire),
    .debug_req_i      (debug_req),
    .wbuf_empty_i     (wbuf_empty),
    .core_sleep_o     (core_sleep),
    .iside_req_i      (iside_req),
    .iside_gnt_i      (iside_gnt),
    .iside_rvalid_i   (iside_rvalid),
    .dside_req_i      (dside_req),
    .dside_gnt_i      (dside_gnt),
    .dside_rvalid_i   (dside_rvalid),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bresp_o   (bresp),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_araddr_i  (araddr),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  // Acknowledge monitor sees the value held over the previous cycle
  always @(posedge clk) begin
    if (irq_ack) begin
      ack_count <= ack_count + 1;
      ack_id_seen <= irq_id;
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the run did not complete", cycle_count);
      $display("Finished with errors");
      $finish;
    end
  end

  // --------------------------------------------------
  // Reporting and reference helpers
  // --------------------------------------------------

  task automatic report_mismatch(input string test_name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    error_count++;
    $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", test_name, expected, actual);
  endtask

  task automatic report_failure(input string test_name, input string what);
    error_count++;
    $display("%s failed: %s", test_name, what);
  endtask

  // Priority from the top is 31 down to 16, then 11, then 3, then 7
  function automatic logic [4:0] expected_winner(input logic [31:0] lines);
    logic [4:0] id;
    logic       found;
    id = 5'd0;
    found = 1'b0;
    for (int i = 31; i >= 16; i--) begin
      if (!found && lines[i]) begin
        id = i[4:0];
        found = 1'b1;
      end
    end
    if (!found && lines[11]) begin
      id = 5'd11;
      found = 1'b1;
    end
    if (!found && lines[3]) begin
      id = 5'd3;
      found = 1'b1;
    end
    if (!found && lines[7]) begin
      id = 5'd7;
    end
    return id;
  endfunction

  // --------------------------------------------------
  // AXI4-Lite master
  // --------------------------------------------------

  // Address and data offered together and held until the ready pulse
  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] wr_resp);
    awaddr = addr;
    wdata = data;
    awvalid = 1'b1;
    wvalid = 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    if (!wready) report_failure("axil_write", "wready not raised together with awready");
    @(negedge clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
    if (!bvalid) report_failure("axil_write", "no write response after the handshake");
    wr_resp = bresp;
    @(negedge clk);
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] rd_resp);
    araddr = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    if (!rvalid) report_failure("axil_read", "no read data after the handshake");
    data = rdata;
    rd_resp = rresp;
    @(negedge clk);
  endtask

  // --------------------------------------------------
  // Core-side helpers
  // --------------------------------------------------

  task automatic wait_for_ack(input string test_name, input int start_count,
                              input int max_cycles);
    int n;
    n = 0;
    while (ack_count == start_count && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (ack_count == start_count) report_failure(test_name, "no acknowledge once enabled");
  endtask

  task automatic enter_sleep(input string test_name);
    int n;
    n = 0;
    wfi_retire = 1'b1;
    @(negedge clk);
    wfi_retire = 1'b0;
    while (!core_sleep && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (!core_sleep) report_failure(test_name, "core did not go to sleep after WFI");
  endtask

  task automatic pulse_debug();
    debug_req = 1'b1;
    @(negedge clk);
    debug_req = 1'b0;
    @(negedge clk);
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------

  task automatic test_register_access();
    tests_run++;
    if ({irq_ack, core_sleep, awready, wready, bvalid, arready, rvalid} !== 7'b0)
      report_failure("register_access", "outputs not low after reset");
    axil_write(`CSR_MIE_OFS, 32'hFFFF_FFFF, resp);
    if (resp !== RESP_OKAY) report_mismatch("register_access", 32'(RESP_OKAY), 32'(resp));
    axil_read(`CSR_MIE_OFS, rd, resp);
    if (rd !== `IRQ_VALID_MASK) report_mismatch("register_access", `IRQ_VALID_MASK, rd);
    if (resp !== RESP_OKAY) report_mismatch("register_access", 32'(RESP_OKAY), 32'(resp));
    axil_write(`CSR_MSTATUS_OFS, 32'h0000_0008, resp);
    axil_read(`CSR_MSTATUS_OFS, rd, resp);
    if (rd !== 32'h0000_0008) report_mismatch("register_access", 32'h0000_0008, rd);
    axil_write(`CSR_MSTATUS_OFS, 32'h0, resp);
    axil_read(`CSR_MSTATUS_OFS, rd, resp);
    if (rd !== 32'h0) report_mismatch("register_access", 32'h0, rd);
    // Read-only register takes the write quietly
    axil_write(`CSR_MIP_OFS, 32'hFFFF_FFFF, resp);
    if (resp !== RESP_OKAY) report_mismatch("register_access", 32'(RESP_OKAY), 32'(resp));
    axil_read(4'h2, rd, resp);
    if (resp !== RESP_SLVERR) report_mismatch("register_access", 32'(RESP_SLVERR), 32'(resp));
    axil_write(`CSR_MIE_OFS, 32'h0, resp);
  endtask

  task automatic test_pending_register();
    logic [31:0] raw;
    tests_run++;
    for (int n = 0; n < 8; n++) begin
      raw = $urandom;
      irq = raw;
      // Held for a cycle before the read
      @(negedge clk);
      axil_read(`CSR_MIP_OFS, rd, resp);
      if (rd !== (raw & `IRQ_VALID_MASK))
        report_mismatch("pending_register", raw & `IRQ_VALID_MASK, rd);
    end
    irq = 32'h0;
    @(negedge clk);
  endtask

  task automatic test_arbitration();
    logic [31:0] pattern;
    logic [4:0]  exp_id;
    tests_run++;
    irq_ready = 1'b1;
    axil_write(`CSR_MIE_OFS, 32'hFFFF_FFFF, resp);
    for (int n = 0; n < 8; n++) begin
      pattern = 32'h0;
      // Several lines at once with every other pattern on the low lines only
      while ($countones(pattern) < 2) begin
        pattern = $urandom & `IRQ_VALID_MASK;
        if (n % 2 == 1) pattern = pattern & 32'h0000_0888;
      end
      exp_id = expected_winner(pattern);
      axil_write(`CSR_MSTATUS_OFS, 32'h0000_0008, resp);
      irq = pattern;
      @(negedge clk);
      if (irq_ack) report_failure("arbitration", "acknowledge one cycle after the lines rose");
      @(negedge clk);
      if (!irq_ack) report_failure("arbitration", "no acknowledge two cycles after the lines rose");
      else if (irq_id !== exp_id) report_mismatch("arbitration", 32'(exp_id), 32'(irq_id));
      @(negedge clk);
      if (irq_ack) report_failure("arbitration", "acknowledge longer than one cycle");
      irq = 32'h0;
      axil_read(`CSR_MSTATUS_OFS, rd, resp);
      if (rd !== 32'h0) report_mismatch("arbitration", 32'h0, rd);
      axil_read(`CSR_IRQ_ID_OFS, rd, resp);
      if (rd !== 32'(exp_id)) report_mismatch("arbitration", 32'(exp_id), rd);
    end
  endtask

  task automatic test_gating();
    int start;
    tests_run++;
    // Global enable off
    axil_write(`CSR_MSTATUS_OFS, 32'h0, resp);
    irq = 32'h1 << 20;
    start = ack_count;
    repeat (6) @(negedge clk);
    if (ack_count != start) report_failure("gating", "acknowledge with global enable off");
    axil_write(`CSR_MSTATUS_OFS, 32'h0000_0008, resp);
    wait_for_ack("gating", start, 8);
    if (ack_id_seen !== 5'd20) report_mismatch("gating", 32'd20, 32'(ack_id_seen));
    irq = 32'h0;
    repeat (2) @(negedge clk);
    // Core not ready
    irq_ready = 1'b0;
    axil_write(`CSR_MSTATUS_OFS, 32'h0000_0008, resp);
    irq = 32'h1 << 11;
    start = ack_count;
    repeat (6) @(negedge clk);
    if (ack_count != start) report_failure("gating", "acknowledge while the core was not ready");
    irq_ready = 1'b1;
    wait_for_ack("gating", start, 8);
    if (ack_id_seen !== 5'd11) report_mismatch("gating", 32'd11, 32'(ack_id_seen));
    irq = 32'h0;
    repeat (2) @(negedge clk);
    // Line disabled in MIE
    axil_write(`CSR_MIE_OFS, 32'h0, resp);
    axil_write(`CSR_MSTATUS_OFS, 32'h0000_0008, resp);
    irq = 32'h1 << 3;
    start = ack_count;
    repeat (6) @(negedge clk);
    if (ack_count != start) report_failure("gating", "acknowledge for a disabled line");
    axil_write(`CSR_MIE_OFS, 32'h0000_0008, resp);
    wait_for_ack("gating", start, 8);
    if (ack_id_seen !== 5'd3) report_mismatch("gating", 32'd3, 32'(ack_id_seen));
    irq = 32'h0;
    repeat (2) @(negedge clk);
  endtask

  task automatic test_sleep_entry();
    logic exp_sleep;
    tests_run++;
    // Idle bus gives sleep on the third edge after the sampling edge
    wfi_retire = 1'b1;
    for (int e = 1; e <= 4; e++) begin
      @(negedge clk);
      wfi_retire = 1'b0;
      exp_sleep = (e == 4);
      if (core_sleep !== exp_sleep)
        report_mismatch("sleep_entry", 32'(exp_sleep), 32'(core_sleep));
    end
    pulse_debug();
    // One granted fetch still in flight
    iside_req = 1'b1;
    iside_gnt = 1'b1;
    @(negedge clk);
    iside_req = 1'b0;
    iside_gnt = 1'b0;
    wfi_retire = 1'b1;
    @(negedge clk);
    wfi_retire = 1'b0;
    repeat (8) begin
      @(negedge clk);
      if (core_sleep) report_failure("sleep_entry", "sleep with a fetch outstanding");
    end
    iside_rvalid = 1'b1;
    @(negedge clk);
    iside_rvalid = 1'b0;
    if (core_sleep) report_failure("sleep_entry", "sleep before the counter drained");
    @(negedge clk);
    if (!core_sleep) report_failure("sleep_entry", "no sleep after the fetch returned");
    pulse_debug();
    // Write buffer still busy
    wbuf_empty = 1'b0;
    wfi_retire = 1'b1;
    @(negedge clk);
    wfi_retire = 1'b0;
    repeat (8) begin
      @(negedge clk);
      if (core_sleep) report_failure("sleep_entry", "sleep with the write buffer busy");
    end
    wbuf_empty = 1'b1;
    @(negedge clk);
    if (!core_sleep) report_failure("sleep_entry", "no sleep after the write buffer drained");
    pulse_debug();
  endtask

  task automatic test_wake();
    int start;
    tests_run++;
    // Enabled line with the global enable off
    axil_write(`CSR_MIE_OFS, 32'h1 << 16, resp);
    axil_write(`CSR_MSTATUS_OFS, 32'h0, resp);
    enter_sleep("wake");
    start = ack_count;
    irq = 32'h1 << 16;
    @(negedge clk);
    if (!core_sleep) report_failure("wake", "sleep ended before the line was pending");
    @(negedge clk);
    if (core_sleep) report_failure("wake", "pending enabled line did not wake the core");
    repeat (4) @(negedge clk);
    if (ack_count != start) report_failure("wake", "acknowledge with global enable off");
    irq = 32'h0;
    repeat (2) @(negedge clk);
    // Debug request
    enter_sleep("wake");
    debug_req = 1'b1;
    @(negedge clk);
    debug_req = 1'b0;
    if (core_sleep) report_failure("wake", "debug request did not wake the core");
    @(negedge clk);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    void'($urandom(32'h8d89));
    rst_n = 1'b0;
    irq = 32'h0;
    irq_ready = 1'b0;
    wfi_retire = 1'b0;
    debug_req = 1'b0;
    wbuf_empty = 1'b1;
    iside_req = 1'b0;
    iside_gnt = 1'b0;
    iside_rvalid = 1'b0;
    dside_req = 1'b0;
    dside_gnt = 1'b0;
    dside_rvalid = 1'b0;
    awaddr = 4'h0;
    awvalid = 1'b0;
    wdata = 32'h0;
    wvalid = 1'b0;
    bready = 1'b1;
    araddr = 4'h0;
    arvalid = 1'b0;
    rready = 1'b1;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_register_access();
    test_pending_register();
    test_arbitration();
    test_gating();
    test_sleep_entry();
    test_wake();
    $display("Tests run: %0d, errors: %0d", tests_run, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : tb_irq_sleep

`default_nettype wire
